//--- logic/channel_extract.sv
`timescale 1ns/10ps
`include "trace_decode_settings.svh"
`default_nettype none

// second stage of the trace decoder, one instance per replay channel
// the channel's slot index picks its payload out of the compacted field and
// the result is registered as that channel's replay record
module channel_extract (
  input  wire                                  clk,
  input  wire                                  rstn,
  input  wire trace_decode_pkg::unpacked_beat_t beat,
  input  wire trace_decode_pkg::slot_t         slot,
  input  wire logic                            chan_logb,
  output trace_decode_pkg::replay_chan_t       rec
);

  // the selected slot, before the channel's own presence bit is applied
  trace_decode_pkg::chan_data_t slot_data;

  // all slots are the same width, so the slot index times the channel width
  // gives the bit offset of the data
  assign slot_data = beat.payload[slot * `TD_CHAN_W +: `TD_CHAN_W];

  //////////////////////////////////////////////////////////////////////
  // record register
  //////////////////////////////////////////////////////////////////////

  // the record is valid for every beat, even one with no packet for this
  // channel, since loge_valid still has to reach the channel
  always_ff @(posedge clk) begin
    if (!rstn) begin
      rec.valid <= 1'b0;
    end else begin
      rec.valid <= beat.valid;
    end
    if (beat.valid) begin
      rec.logb_valid <= chan_logb;
      rec.loge_valid <= beat.loge_valid;
      // when the channel has no packet its slot index points at another
      // channel's data or at an empty slot, so the payload is forced to zero
      if (chan_logb) begin
        rec.payload <= slot_data;
      end else begin
        rec.payload <= '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/replay_fanout.sv
`timescale 1ns/10ps
`include "trace_decode_settings.svh"
`default_nettype none

// last stage of the trace decoder
// the channel records are registered once more onto the outputs, and the
// consumers' almost-full flags are folded into the input ready
module replay_fanout (
  input  wire                                clk,
  input  wire                                rstn,
  input  wire trace_decode_pkg::replay_chan_t recs [0:`TD_CHAN_CNT-1],
  input  wire trace_decode_pkg::chan_mask_t  almful,
  output trace_decode_pkg::replay_chan_t     chan_out [0:`TD_CHAN_CNT-1],
  output logic                               ready
);

  // set when at least one consumer is running low on space
  logic any_almful;

  // the outputs never stall, so a single busy consumer has to hold back
  // the whole input, even for channels that still have room
  assign any_almful = |almful;

  //////////////////////////////////////////////////////////////////////
  // output records
  //////////////////////////////////////////////////////////////////////

  // every channel is registered alike, only the valid bits see reset
  always_ff @(posedge clk) begin
    for (int c = 0; c < `TD_CHAN_CNT; c++) begin
      if (!rstn) begin
        chan_out[c].valid <= 1'b0;
      end else begin
        chan_out[c].valid <= recs[c].valid;
      end
      chan_out[c].logb_valid <= recs[c].logb_valid;
      chan_out[c].payload    <= recs[c].payload;
      chan_out[c].loge_valid <= recs[c].loge_valid;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // input back-pressure
  //////////////////////////////////////////////////////////////////////

  // ready comes out of reset high so the first beat can enter at once
  // the one cycle of delay here plus the three pipeline stages is the
  // headroom a consumer must still have when it raises almful
  always_ff @(posedge clk) begin
    if (!rstn) begin
      ready <= 1'b1;
    end else begin
      ready <= !any_almful;
    end
  end

endmodule

`default_nettype wire

//--- logic/trace_decode_pkg.sv
`include "trace_decode_settings.svh"
`default_nettype none

// shared types of the replay-side trace decoder
package trace_decode_pkg;

  // one bit per channel, used for logb_valid, loge_valid and almful
  typedef logic [`TD_CHAN_CNT-1:0] chan_mask_t;

  // payload of a single channel
  typedef logic [`TD_CHAN_W-1:0] chan_data_t;

  // compacted payload field of a beat, slot 0 at the least significant end
  typedef logic [`TD_CHAN_CNT*`TD_CHAN_W-1:0] packed_data_t;

  // position of one channel's data in the compacted field
  typedef logic [`TD_SLOT_W-1:0] slot_t;

  // beat as it arrives from the replay log
  // the first member sits at the top, so from the lsb upwards the beat reads
  // logb_valid, then loge_valid, then the compacted payload
  typedef struct packed {
    packed_data_t payload;
    chan_mask_t   loge_valid;
    chan_mask_t   logb_valid;
  } packed_trace_t;

  // beat after the first register stage of the decoder
  // valid marks a cycle where the beat was really accepted
  typedef struct packed {
    logic         valid;
    chan_mask_t   logb_valid;
    chan_mask_t   loge_valid;
    packed_data_t payload;
  } unpacked_beat_t;

  // record handed to one replay channel
  // each channel carries the full loge_valid vector since the channels
  // drain independently and must each judge the end events of all others
  typedef struct packed {
    logic       valid;
    logic       logb_valid;
    chan_data_t payload;
    chan_mask_t loge_valid;
  } replay_chan_t;

endpackage

`default_nettype wire

//--- logic/trace_decode_settings.svh
`ifndef TRACE_DECODE_SETTINGS_SVH
`define TRACE_DECODE_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// replay trace decoder sizing
//////////////////////////////////////////////////////////////////////

// number of independent replay channels that share one trace beat
// every channel owns one logb_valid bit and one loge_valid bit
`define TD_CHAN_CNT 4

// payload width of a single channel
// all channels share this width, so the compacted field is a row of
// equal slots and a slot index alone locates a channel's data
`define TD_CHAN_W 32

// width of a slot index inside the compacted payload field
// it must hold the largest count of present channels below the last
// channel, which is TD_CHAN_CNT - 1
`define TD_SLOT_W 2

// the compacted payload is TD_CHAN_CNT slots of TD_CHAN_W bits each,
// even though a sparse beat only fills the lowest slots of it

`endif

//--- logic/trace_decoder.sv
`timescale 1ns/10ps
`include "trace_decode_settings.svh"
`default_nettype none

// replay-side trace decoder
// one packed beat from the replay log is split into one record per replay
// channel, three register stages after it was accepted
// the unpacker locates every channel in the compacted payload, one extractor
// per channel pulls its data out, and the fanout drives the outputs and
// turns the consumers' almost-full flags into ready
module trace_decoder (
  input  wire                                  clk,
  input  wire                                  rstn,
  input  wire logic                            valid,
  input  wire trace_decode_pkg::packed_trace_t trace,
  output logic                                 ready,
  output trace_decode_pkg::replay_chan_t       chan_out [0:`TD_CHAN_CNT-1],
  input  wire trace_decode_pkg::chan_mask_t    almful
);

  // registered beat and the slot of each channel within its payload
  wire trace_decode_pkg::unpacked_beat_t beat;
  wire trace_decode_pkg::slot_t          slots [0:`TD_CHAN_CNT-1];

  // per channel records between the extractors and the fanout
  wire trace_decode_pkg::replay_chan_t   recs [0:`TD_CHAN_CNT-1];

  // ready is produced by the fanout and fed back to gate acceptance
  trace_unpacker i_unpacker (
    .clk      (clk),
    .rstn     (rstn),
    .in_valid (valid),
    .ready    (ready),
    .trace    (trace),
    .beat     (beat),
    .slots    (slots)
  );

  //////////////////////////////////////////////////////////////////////
  // one extractor per replay channel
  //////////////////////////////////////////////////////////////////////

  // each extractor sees the whole beat but only its own slot and presence bit
  for (genvar c = 0; c < `TD_CHAN_CNT; c++) begin : g_chan
    channel_extract i_extract (
      .clk       (clk),
      .rstn      (rstn),
      .beat      (beat),
      .slot      (slots[c]),
      .chan_logb (beat.logb_valid[c]),
      .rec       (recs[c])
    );
  end

  replay_fanout i_fanout (
    .clk      (clk),
    .rstn     (rstn),
    .recs     (recs),
    .almful   (almful),
    .chan_out (chan_out),
    .ready    (ready)
  );

endmodule

`default_nettype wire

//--- logic/trace_unpacker.sv
`timescale 1ns/10ps
`include "trace_decode_settings.svh"
`default_nettype none

// first stage of the trace decoder
// an accepted beat is registered whole, and next to it the slot index of
// every channel in the compacted payload is registered
// a channel's slot is the number of present channels below it, because the
// replay log packs present payloads from the lsb upwards in channel order
module trace_unpacker (
  input  wire                              clk,
  input  wire                              rstn,
  input  wire logic                        in_valid,
  input  wire logic                        ready,
  input  wire trace_decode_pkg::packed_trace_t trace,
  output trace_decode_pkg::unpacked_beat_t beat,
  output trace_decode_pkg::slot_t          slots [0:`TD_CHAN_CNT-1]
);

  //////////////////////////////////////////////////////////////////////
  // slot index computation
  //////////////////////////////////////////////////////////////////////

  // counts the set mask bits strictly below channel chan
  // the loop runs over the full mask so that it unrolls to a fixed adder
  function automatic trace_decode_pkg::slot_t count_below(
    input trace_decode_pkg::chan_mask_t mask,
    input int                           chan
  );
    trace_decode_pkg::slot_t cnt;
    cnt = '0;
    for (int i = 0; i < `TD_CHAN_CNT; i++) begin
      if (i < chan && mask[i]) begin
        cnt = cnt + trace_decode_pkg::slot_t'(1);
      end
    end
    return cnt;
  endfunction

  // a beat moves only when the sender offers it and the decoder has room
  logic accept;

  // slot indices of the beat at the input, before the register
  trace_decode_pkg::slot_t slot_nxt [0:`TD_CHAN_CNT-1];

  assign accept = in_valid && ready;

  // channel 0 always lands in slot 0, the others depend on the bits below
  always_comb begin
    for (int c = 0; c < `TD_CHAN_CNT; c++) begin
      slot_nxt[c] = count_below(trace.logb_valid, c);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // beat register
  //////////////////////////////////////////////////////////////////////

  // valid follows the handshake every cycle so a refused beat leaves a bubble
  // the fields only load on acceptance and hold otherwise
  always_ff @(posedge clk) begin
    if (!rstn) begin
      beat.valid <= 1'b0;
    end else begin
      beat.valid <= accept;
    end
    if (accept) begin
      beat.logb_valid <= trace.logb_valid;
      beat.loge_valid <= trace.loge_valid;
      beat.payload    <= trace.payload;
      for (int c = 0; c < `TD_CHAN_CNT; c++) begin
        slots[c] <= slot_nxt[c];
      end
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# compile and run the trace decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_trace_decoder \
  --Mdir "$BUILD_DIR" -o sim_trace_decoder
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

"./$BUILD_DIR/sim_trace_decoder" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -q "Simulation completed successfully" "$LOG"; then
  echo "no result line found in $LOG"
  exit 1
fi
exit 0

//--- sim.f
+incdir+logic
logic/trace_decode_pkg.sv
logic/trace_unpacker.sv
logic/channel_extract.sv
logic/replay_fanout.sv
logic/trace_decoder.sv
verification/trace_decoder_sva.sv
verification/tb_trace_decoder.sv

//--- verification/tb_trace_decoder.sv
`timescale 1ns/10ps
`include "trace_decode_settings.svh"
`default_nettype none

// testbench of the replay-side trace decoder
// every table row becomes one beat: the testbench packs the present payloads
// itself and predicts each channel's record from the unpacked row values
module tb_trace_decoder;

  //////////////////////////////////////////////////////////////////////
  // constants and types
  //////////////////////////////////////////////////////////////////////

  localparam int CLK_PERIOD = 4;
  localparam int RESET_CYCLES = 16;
  localparam int ROWS = 16;
  // 20 cycles per row leaves room for stalls and the pipeline drain
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + ROWS * 20;

  // one stimulus row
  // fill is the junk that sits in the unused upper slots of the payload
  typedef struct packed {
    trace_decode_pkg::chan_mask_t                   logb;
    trace_decode_pkg::chan_mask_t                   loge;
    trace_decode_pkg::chan_mask_t                   almful;
    trace_decode_pkg::packed_data_t                 fill;
    trace_decode_pkg::chan_data_t [`TD_CHAN_CNT-1:0] data;
  } stim_row_t;

  // the four records that one beat produces
  typedef trace_decode_pkg::replay_chan_t [`TD_CHAN_CNT-1:0] rec_set_t;

  //////////////////////////////////////////////////////////////////////
  // DUT signals
  //////////////////////////////////////////////////////////////////////

  logic                            clk = 1'b0;
  logic                            rstn;
  logic                            valid;
  trace_decode_pkg::packed_trace_t trace;
  logic                            ready;
  trace_decode_pkg::replay_chan_t  chan_out [0:`TD_CHAN_CNT-1];
  trace_decode_pkg::chan_mask_t    almful;

  // stimulus table and the row currently offered to the DUT
  stim_row_t rows [0:ROWS-1];
  string     row_name [0:ROWS-1];
  int        n_rows;
  stim_row_t cur_row;
  string     cur_name;
  integer    seed;

  // expected beats in acceptance order, with the cycle where each is due
  int        exp_due [$];
  rec_set_t  exp_recs [$];
  string     exp_name [$];

  // monitor state
  int        cycle = 0;
  logic      checking;
  logic      exp_ready;

  trace_decoder i_dut (
    .clk      (clk),
    .rstn     (rstn),
    .valid    (valid),
    .trace    (trace),
    .ready    (ready),
    .chan_out (chan_out),
    .almful   (almful)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // counts rising edges, read by the monitor on the falling edge
  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  // compares one value and stops the run at the first mismatch
  task automatic check_equal(input string test, input string what,
                             input logic [63:0] expected, input logic [63:0] actual);
    if (expected !== actual) begin
      $display("error: test %s, %s expected %h actual %h", test, what, expected, actual);
      $display("Simulation failed");
      $fatal(1, "mismatch in test %s", test);
    end
  endtask

  // appends a row with random payloads and random junk in the spare slots
  task automatic add_row(input string name, input trace_decode_pkg::chan_mask_t logb,
                         input trace_decode_pkg::chan_mask_t loge,
                         input trace_decode_pkg::chan_mask_t alm);
    stim_row_t row;
    row.logb   = logb;
    row.loge   = loge;
    row.almful = alm;
    for (int c = 0; c < `TD_CHAN_CNT; c++) begin
      row.data[c] = $random(seed);
    end
    for (int k = 0; k < `TD_CHAN_CNT; k++) begin
      row.fill[k*`TD_CHAN_W +: `TD_CHAN_W] = $random(seed);
    end
    rows[n_rows]     = row;
    row_name[n_rows] = name;
    n_rows++;
  endtask

  // the stimulus table, one beat per line: logb_valid, loge_valid, almful
  task automatic load_table();
    add_row("full_beat",           4'b1111, 4'b1111, 4'b0000);
    add_row("full_beat_loge_5",    4'b1111, 4'b0101, 4'b0000);
    add_row("sparse_1010",         4'b1010, 4'b0011, 4'b0000);
    add_row("sparse_0100",         4'b0100, 4'b1000, 4'b0000);
    add_row("sparse_0001",         4'b0001, 4'b0000, 4'b0000);
    add_row("sparse_1000",         4'b1000, 4'b0001, 4'b0000);
    add_row("sparse_0110",         4'b0110, 4'b1111, 4'b0000);
    add_row("no_packets",          4'b0000, 4'b1001, 4'b0000);
    add_row("almful_raise",        4'b0101, 4'b0010, 4'b0010);
    add_row("stall_almful_again",  4'b1011, 4'b0100, 4'b1000);
    add_row("stall_release",       4'b0111, 4'b0110, 4'b0101);
    add_row("after_release",       4'b1101, 4'b1110, 4'b0000);
    add_row("b2b_first",           4'b1001, 4'b0001, 4'b0000);
    add_row("b2b_second",          4'b1110, 4'b0000, 4'b0000);
    add_row("b2b_third",           4'b0011, 4'b1010, 4'b0000);
    add_row("b2b_last",            4'b1111, 4'b0000, 4'b0000);
  endtask

  // reference packing: present channels fill slots from the lsb upwards,
  // in channel order, and the slots above them keep the junk fill
  function automatic trace_decode_pkg::packed_trace_t pack_beat(input stim_row_t row);
    trace_decode_pkg::packed_trace_t t;
    int slot;
    t.logb_valid = row.logb;
    t.loge_valid = row.loge;
    t.payload    = row.fill;
    slot         = 0;
    for (int c = 0; c < `TD_CHAN_CNT; c++) begin
      if (row.logb[c]) begin
        t.payload[slot*`TD_CHAN_W +: `TD_CHAN_W] = row.data[c];
        slot++;
      end
    end
    return t;
  endfunction

  // every channel gets a valid record with the full loge_valid copy
  // an absent channel shows a zero payload
  function automatic rec_set_t expected_set(input stim_row_t row);
    rec_set_t s;
    for (int c = 0; c < `TD_CHAN_CNT; c++) begin
      s[c].valid      = 1'b1;
      s[c].logb_valid = row.logb[c];
      s[c].payload    = row.logb[c] ? row.data[c] : '0;
      s[c].loge_valid = row.loge;
    end
    return s;
  endfunction

  // offers one row until the DUT takes it
  // a row's almful is raised with the beat and drops once the beat stalls,
  // as a consumer would after draining
  task automatic apply_row(input int r);
    logic accepted;
    cur_row  = rows[r];
    cur_name = row_name[r];
    trace    = pack_beat(rows[r]);
    valid    = 1'b1;
    almful   = rows[r].almful;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = ready;
      @(posedge clk);
      #1;
      if (!accepted) begin
        almful = '0;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // monitor
  //////////////////////////////////////////////////////////////////////

  // runs on the falling edge where all DUT outputs are settled
  // a beat taken at the next rising edge shows on chan_out three falling
  // edges later, and ready follows the almful seen at the previous edge
  always @(negedge clk) begin
    rec_set_t exp_set;
    if (checking) begin
      check_equal("ready_model", "ready", 64'(exp_ready), 64'(ready));
      if (exp_due.size() != 0 && exp_due[0] == cycle) begin
        exp_set = exp_recs.pop_front();
        for (int c = 0; c < `TD_CHAN_CNT; c++) begin
          check_equal(exp_name[0], $sformatf("chan %0d record", c),
                      64'(exp_set[c]), 64'(chan_out[c]));
        end
        exp_due.pop_front();
        exp_name.pop_front();
      end else begin
        for (int c = 0; c < `TD_CHAN_CNT; c++) begin
          check_equal("no_beat_due", $sformatf("chan %0d valid", c),
                      64'(1'b0), 64'(chan_out[c].valid));
        end
      end
      if (valid && ready) begin
        exp_due.push_back(cycle + 3);
        exp_recs.push_back(expected_set(cur_row));
        exp_name.push_back(cur_name);
      end
      exp_ready = !(|almful);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus and end of run
  //////////////////////////////////////////////////////////////////////

  initial begin
    rstn           = 1'b0;
    valid          = 1'b0;
    trace          = '0;
    almful         = '0;
    checking       = 1'b0;
    exp_ready      = 1'b1;
    n_rows         = 0;
    seed           = 32'hf9eec7d6;
    cur_row        = '0;
    cur_name       = "idle";
    load_table();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rstn     = 1'b1;
    checking = 1'b1;
    // nothing has been offered yet, so this is the plain reset state
    @(negedge clk);
    check_equal("reset_state", "ready", 64'(1'b1), 64'(ready));
    for (int c = 0; c < `TD_CHAN_CNT; c++) begin
      check_equal("reset_state", $sformatf("chan %0d valid", c),
                  64'(1'b0), 64'(chan_out[c].valid));
    end
    @(posedge clk);
    #1;
    for (int r = 0; r < n_rows; r++) begin
      apply_row(r);
    end
    valid  = 1'b0;
    almful = '0;
    // let the pipeline drain and watch a few idle cycles behind it
    while (exp_due.size() != 0) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    $display("Simulation completed successfully");
    $finish;
  end

  // a stuck handshake must not hang the run
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog: the run did not finish in %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $fatal(1, "watchdog timeout");
  end

endmodule

`default_nettype wire

//--- verification/trace_decoder_sva.sv
`timescale 1ns/10ps
`include "trace_decode_settings.svh"
`default_nettype none

// handshake and reset properties of the trace decoder top level
module trace_decoder_sva (
  input wire                                 clk,
  input wire                                 rstn,
  input wire logic                           valid,
  input wire logic                           ready,
  input wire trace_decode_pkg::chan_mask_t   almful,
  input wire trace_decode_pkg::replay_chan_t chan_out [0:`TD_CHAN_CNT-1]
);

  // valid bits of all output records side by side
  logic [`TD_CHAN_CNT-1:0] out_valid;

  always_comb begin
    for (int c = 0; c < `TD_CHAN_CNT; c++) begin
      out_valid[c] = chan_out[c].valid;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // properties
  //////////////////////////////////////////////////////////////////////

  // ready leaves reset high so the first beat can enter at once
  ready_after_reset: assert property (@(posedge clk) $rose(rstn) |-> ready)
    else $error("ready low in the first cycle after reset");

  // a record only leaves the pipeline for a beat taken three edges before
  valid_needs_accept: assert property (@(posedge clk) disable iff (!rstn)
    (|out_valid) |-> $past(valid && ready, 3))
    else $error("chan_out valid without a matching acceptance");

  // any consumer running low holds back the input on the next cycle
  ready_drops_on_almful: assert property (@(posedge clk) disable iff (!rstn)
    (|almful) |=> !ready)
    else $error("ready still high one cycle after almful");

endmodule

bind trace_decoder trace_decoder_sva i_sva (
  .clk      (clk),
  .rstn     (rstn),
  .valid    (valid),
  .ready    (ready),
  .almful   (almful),
  .chan_out (chan_out)
);

`default_nettype wire
